// File: source/calc_pkg.sv
package calc_pkg;

  localparam int DATA_W  = 16;  // Operand and result width
  localparam int DIGIT_W = 4;   // One hex digit and also the shift per digit
  localparam int KEY_W   = 5;   // Kind bit plus four value bits

  typedef logic [DATA_W-1:0] data_t;

  // Function keys 0 to 3 carry the operation code directly
  typedef enum logic [1:0] {
    OP_ADD = 2'd0,
    OP_SUB = 2'd1,
    OP_MUL = 2'd2,
    OP_DIV = 2'd3
  } op_t;

  localparam logic [DIGIT_W-1:0] KEY_NEG = 4'd4;  // Negate the value being entered
  localparam logic [DIGIT_W-1:0] KEY_EQ  = 4'd5;  // Equals
  localparam logic [DIGIT_W-1:0] KEY_AC  = 4'd6;  // All clear

  typedef struct packed {
    logic               is_func;  // Zero for a digit key
    logic [DIGIT_W-1:0] value;    // Hex digit 0 to F
  } digit_key_t;

  typedef struct packed {
    logic               is_func;  // One for a function key
    logic [DIGIT_W-1:0] code;     // Operation or control code
  } func_key_t;

  // The same key word read as a digit or as a function
  typedef union packed {
    digit_key_t digit;
    func_key_t  func;
  } key_code_t;

endpackage

// File: source/calc_ctrl_if.sv
`timescale 1ns/1ns

interface calc_ctrl_if;

  logic                           clear;        // Zero both registers and flags
  logic                           load_digit;   // Shift in one digit
  logic [calc_pkg::DIGIT_W-1:0]   digit;
  logic                           target_b;     // Load and negate act on B when set
  logic                           negate;       // Two's complement of the target
  logic                           take_result;  // A takes the ALU result
  calc_pkg::data_t                result;
  logic                           copy_a_to_b;  // For A op A on equals
  logic                           clear_b;      // Zero B, its flag and b_entered

  calc_pkg::data_t                reg_a;
  calc_pkg::data_t                reg_b;
  logic                           b_entered;    // At least one digit went into B

  modport seq (
    output clear, load_digit, digit, target_b, negate,
    output take_result, result, copy_a_to_b, clear_b,
    input  reg_a, reg_b, b_entered
  );

  modport dp (
    input  clear, load_digit, digit, target_b, negate,
    input  take_result, result, copy_a_to_b, clear_b,
    output reg_a, reg_b, b_entered
  );

endinterface

// File: source/calc_alu.sv
`timescale 1ns/1ns

module calc_alu (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            i_start,
  input  calc_pkg::op_t   i_op,
  input  calc_pkg::data_t i_a,
  input  calc_pkg::data_t i_b,
  input  logic            i_signed,
  output logic            o_done,
  output calc_pkg::data_t o_result,
  output logic            o_div_zero
);

  localparam int MSB = calc_pkg::DATA_W - 1;

  calc_pkg::data_t mag_a;
  calc_pkg::data_t mag_b;
  calc_pkg::data_t quot;
  calc_pkg::data_t div_res;
  calc_pkg::data_t result;
  logic            b_zero;

  assign b_zero = (i_b == '0);

  // Signed divide works on magnitudes so it truncates toward zero
  assign mag_a   = (i_signed && i_a[MSB]) ? -i_a : i_a;
  assign mag_b   = (i_signed && i_b[MSB]) ? -i_b : i_b;
  assign quot    = b_zero ? '0 : (mag_a / mag_b);
  assign div_res = (i_signed && (i_a[MSB] ^ i_b[MSB])) ? -quot : quot;

  // Add, subtract and the low half of a product are the same in both modes
  always_comb
  begin
    case (i_op)
      calc_pkg::OP_ADD: result = i_a + i_b;
      calc_pkg::OP_SUB: result = i_a - i_b;
      calc_pkg::OP_MUL: result = i_a * i_b;
      default:          result = div_res;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      o_done     <= 1'b0;
      o_div_zero <= 1'b0;
    end
    else
    begin
      o_done     <= i_start;
      o_div_zero <= i_start && (i_op == calc_pkg::OP_DIV) && b_zero;
    end
  end

  always_ff @(posedge clk)
  begin
    if (i_start)
    begin
      o_result <= result;
    end
  end

  // Each start is a single strobe answered by o_done on the next cycle
  assert property (@(posedge clk) disable iff (!rst_n) i_start |=> o_done && !i_start);

endmodule

// File: source/operand_datapath.sv
`timescale 1ns/1ns

module operand_datapath (
  input  logic    clk,
  input  logic    rst_n,
  calc_ctrl_if.dp ctrl
);

  localparam int DATA_W  = calc_pkg::DATA_W;
  localparam int DIGIT_W = calc_pkg::DIGIT_W;

  calc_pkg::data_t reg_a;
  calc_pkg::data_t reg_b;
  logic            neg_a;      // A is being entered as a negative number
  logic            neg_b;
  logic            b_entered;

  calc_pkg::data_t base;       // Register the adder works on
  logic            base_neg;
  calc_pkg::data_t digit_ext;
  calc_pkg::data_t add_a;
  calc_pkg::data_t add_b;
  logic            add_cin;
  calc_pkg::data_t add_sum;
  logic            use_a;
  logic            use_b;

  assign use_a = (ctrl.load_digit || ctrl.negate) && !ctrl.target_b;
  assign use_b = (ctrl.load_digit || ctrl.negate) && ctrl.target_b;

  // One adder serves both shift-plus-or-minus-digit and negate
  always_comb
  begin
    base      = ctrl.target_b ? reg_b : reg_a;
    base_neg  = ctrl.target_b ? neg_b : neg_a;
    digit_ext = {{(DATA_W - DIGIT_W){1'b0}}, ctrl.digit};
    if (ctrl.clear)
    begin
      base     = '0;  // Digit lands on a freshly cleared register
      base_neg = 1'b0;
    end
    if (ctrl.negate)
    begin
      add_a   = ~base;
      add_b   = '0;
      add_cin = 1'b1;
    end
    else
    begin
      add_a   = {base[DATA_W-DIGIT_W-1:0], {DIGIT_W{1'b0}}};
      add_b   = base_neg ? ~digit_ext : digit_ext;  // Subtracting is adding the inverse plus one
      add_cin = base_neg;
    end
  end

  assign add_sum = add_a + add_b + {{(DATA_W - 1){1'b0}}, add_cin};

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      reg_a     <= '0;
      reg_b     <= '0;
      neg_a     <= 1'b0;
      neg_b     <= 1'b0;
      b_entered <= 1'b0;
    end
    else
    begin
      if (use_a)
      begin
        reg_a <= add_sum;
      end
      else if (ctrl.clear)
      begin
        reg_a <= '0;
      end
      else if (ctrl.take_result)
      begin
        reg_a <= ctrl.result;
      end

      if (ctrl.clear || ctrl.clear_b)
      begin
        reg_b     <= '0;
        neg_b     <= 1'b0;
        b_entered <= 1'b0;
      end
      else
      begin
        if (use_b)
        begin
          reg_b <= add_sum;
        end
        else if (ctrl.copy_a_to_b)
        begin
          reg_b <= reg_a;
        end
        if (ctrl.negate && ctrl.target_b)
        begin
          neg_b <= ~neg_b;
        end
        if (ctrl.load_digit && ctrl.target_b)
        begin
          b_entered <= 1'b1;
        end
      end

      if (ctrl.clear)
      begin
        neg_a <= 1'b0;
      end
      else if (ctrl.negate && !ctrl.target_b)
      begin
        neg_a <= ~neg_a;
      end
    end
  end

  assign ctrl.reg_a     = reg_a;
  assign ctrl.reg_b     = reg_b;
  assign ctrl.b_entered = b_entered;

  // The sequencer never asks the adder and the result path for two things at once
  assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({ctrl.load_digit, ctrl.negate, ctrl.take_result}));

endmodule

// File: source/calc_sequencer.sv
`timescale 1ns/1ns

module calc_sequencer (
  input  logic                clk,
  input  logic                rst_n,
  input  calc_pkg::key_code_t i_key,
  input  logic                i_key_valid,
  output logic                o_key_ready,
  input  logic                i_signed_mode,
  calc_ctrl_if.seq            ctrl,
  output logic                o_alu_start,
  output calc_pkg::op_t       o_alu_op,
  input  logic                i_alu_done,
  input  calc_pkg::data_t     i_alu_result,
  input  logic                i_alu_div_zero,
  output calc_pkg::data_t     o_disp_data,
  output logic                o_disp_valid,
  input  logic                i_disp_ready,
  output logic [3:0]          o_op_lamps,
  output logic                o_error
);

  typedef enum logic [2:0] {
    S_WAIT_A,   // Entering the first operand
    S_WAIT_B,   // Entering the second operand while an operation is pending
    S_WAIT_EQ,  // Result of equals on show
    S_CALC,
    S_ALU,
    S_SHOW,
    S_DISP,
    S_ERROR
  } state_t;

  state_t              state;
  state_t              ret_state;  // Wait state to return to after the display
  logic                pending;
  calc_pkg::op_t       cur_op;
  logic                show_b;
  calc_pkg::key_code_t key_q;      // Operator or equals that started a calculation
  calc_pkg::data_t     disp_q;

  logic key_fire;
  logic live;                      // Accepting more than all clear
  logic is_op;
  logic do_digit;
  logic do_op;
  logic do_neg;
  logic do_eq;
  logic do_ac;
  logic do_calc;
  logic alu_ok;

  assign o_key_ready = (state == S_WAIT_A) || (state == S_WAIT_B) ||
                       (state == S_WAIT_EQ) || (state == S_ERROR);
  assign key_fire    = i_key_valid && o_key_ready;
  assign live        = key_fire && (state != S_ERROR);

  // Codes 0 to 3 are the operations themselves
  assign is_op    = i_key.func.is_func && (i_key.func.code[3:2] == 2'b00);
  assign do_digit = live && !i_key.digit.is_func;
  assign do_op    = live && is_op;
  assign do_neg   = live && i_key.func.is_func && (i_key.func.code == calc_pkg::KEY_NEG) &&
                    i_signed_mode;
  assign do_eq    = live && i_key.func.is_func && (i_key.func.code == calc_pkg::KEY_EQ) &&
                    (state == S_WAIT_B);
  assign do_ac    = key_fire && i_key.func.is_func && (i_key.func.code == calc_pkg::KEY_AC);
  assign do_calc  = do_eq || (do_op && (state == S_WAIT_B) && ctrl.b_entered);
  assign alu_ok   = (state == S_ALU) && i_alu_done && !i_alu_div_zero;

  // A digit after equals clears and loads in the same cycle
  assign ctrl.clear       = do_ac || (do_digit && (state == S_WAIT_EQ));
  assign ctrl.load_digit  = do_digit;
  assign ctrl.digit       = i_key.digit.value;
  assign ctrl.target_b    = (state == S_WAIT_B);
  assign ctrl.negate      = do_neg;
  assign ctrl.copy_a_to_b = do_eq && !ctrl.b_entered;
  assign ctrl.take_result = alu_ok;
  assign ctrl.clear_b     = alu_ok;  // B is used up by every calculation
  assign ctrl.result      = i_alu_result;

  assign o_alu_start  = (state == S_CALC);
  assign o_alu_op     = cur_op;
  assign o_disp_data  = disp_q;
  assign o_disp_valid = (state == S_DISP);
  assign o_op_lamps   = pending ? (4'b0001 << cur_op) : 4'b0000;
  assign o_error      = (state == S_ERROR);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= S_SHOW;  // Reset shows the cleared A like all clear
      ret_state <= S_WAIT_A;
      pending   <= 1'b0;
      cur_op    <= calc_pkg::OP_ADD;
      show_b    <= 1'b0;
    end
    else
    begin
      case (state)
        S_WAIT_A, S_WAIT_B, S_WAIT_EQ, S_ERROR:
        begin
          if (do_ac)
          begin
            pending   <= 1'b0;
            show_b    <= 1'b0;
            ret_state <= S_WAIT_A;
            state     <= S_SHOW;
          end
          else if (do_calc)
          begin
            state <= S_CALC;
          end
          else if (do_op)
          begin
            pending   <= 1'b1;  // Replaces the pending operation when B is empty
            cur_op    <= calc_pkg::op_t'(i_key.func.code[1:0]);
            show_b    <= 1'b0;
            ret_state <= S_WAIT_B;
            state     <= S_SHOW;
          end
          else if (do_digit)
          begin
            show_b    <= (state == S_WAIT_B);
            ret_state <= (state == S_WAIT_B) ? S_WAIT_B : S_WAIT_A;
            state     <= S_SHOW;
          end
          else if (do_neg)
          begin
            show_b    <= (state == S_WAIT_B);
            ret_state <= state;
            state     <= S_SHOW;
          end
        end
        S_CALC:
        begin
          state <= S_ALU;
        end
        S_ALU:
        begin
          if (i_alu_done && i_alu_div_zero)
          begin
            pending <= 1'b0;
            state   <= S_ERROR;
          end
          else if (i_alu_done)
          begin
            show_b <= 1'b0;
            state  <= S_SHOW;
            if (key_q.func.code == calc_pkg::KEY_EQ)
            begin
              pending   <= 1'b0;
              ret_state <= S_WAIT_EQ;
            end
            else
            begin
              cur_op    <= calc_pkg::op_t'(key_q.func.code[1:0]);  // Chained operator
              ret_state <= S_WAIT_B;
            end
          end
        end
        S_SHOW:
        begin
          state <= S_DISP;
        end
        S_DISP:
        begin
          if (i_disp_ready)
          begin
            state <= ret_state;
          end
        end
        default:
        begin
          state <= S_SHOW;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (key_fire)
    begin
      key_q <= i_key;
    end
    if (state == S_SHOW)
    begin
      disp_q <= show_b ? ctrl.reg_b : ctrl.reg_a;
    end
  end

  // The receiver may sample the word on any cycle of the wait
  assert property (@(posedge clk) disable iff (!rst_n)
    o_disp_valid && !i_disp_ready |=> o_disp_valid && $stable(o_disp_data));

endmodule

// File: source/calc_top.sv
`timescale 1ns/1ns

module calc_top (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [calc_pkg::KEY_W-1:0] i_key,
  input  logic                       i_key_valid,
  output logic                       o_key_ready,
  input  logic                       i_signed_mode,
  output calc_pkg::data_t            o_disp_data,
  output logic                       o_disp_valid,
  input  logic                       i_disp_ready,
  output logic [3:0]                 o_op_lamps,
  output logic                       o_error
);

  calc_ctrl_if ctrl ();

  logic            alu_start;
  calc_pkg::op_t   alu_op;
  logic            alu_done;
  calc_pkg::data_t alu_result;
  logic            alu_div_zero;

  calc_sequencer i_sequencer (
    .clk            (clk),
    .rst_n          (rst_n),
    .i_key          (i_key),
    .i_key_valid    (i_key_valid),
    .o_key_ready    (o_key_ready),
    .i_signed_mode  (i_signed_mode),
    .ctrl           (ctrl.seq),
    .o_alu_start    (alu_start),
    .o_alu_op       (alu_op),
    .i_alu_done     (alu_done),
    .i_alu_result   (alu_result),
    .i_alu_div_zero (alu_div_zero),
    .o_disp_data    (o_disp_data),
    .o_disp_valid   (o_disp_valid),
    .i_disp_ready   (i_disp_ready),
    .o_op_lamps     (o_op_lamps),
    .o_error        (o_error)
  );

  operand_datapath i_datapath (
    .clk   (clk),
    .rst_n (rst_n),
    .ctrl  (ctrl.dp)
  );

  // The ALU reads the operands straight from the datapath registers
  calc_alu i_alu (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_start    (alu_start),
    .i_op       (alu_op),
    .i_a        (ctrl.reg_a),
    .i_b        (ctrl.reg_b),
    .i_signed   (i_signed_mode),
    .o_done     (alu_done),
    .o_result   (alu_result),
    .o_div_zero (alu_div_zero)
  );

endmodule

// File: test/calc_model.svh
`ifndef CALC_MODEL_SVH
`define CALC_MODEL_SVH

typedef enum int {
  M_ENTER_A,
  M_ENTER_B,   // An operation is pending and B takes the digits
  M_AFTER_EQ,
  M_ERROR
} model_state_t;

model_state_t    m_state;
calc_pkg::data_t m_a;
calc_pkg::data_t m_b;
bit              m_neg_a;
bit              m_neg_b;
bit              m_b_entered;
bit              m_pending;
calc_pkg::op_t   m_op;

function automatic void clear_operand_b();
  m_b         = '0;
  m_neg_b     = 1'b0;
  m_b_entered = 1'b0;
endfunction

function automatic void clear_model();
  clear_operand_b();
  m_state   = M_ENTER_A;
  m_a       = '0;
  m_neg_a   = 1'b0;
  m_pending = 1'b0;
  m_op      = calc_pkg::OP_ADD;
endfunction

// A negative entry subtracts each new digit
function automatic calc_pkg::data_t shift_digit(input calc_pkg::data_t value, input bit neg,
                                                input logic [3:0] d);
  calc_pkg::data_t shifted;
  shifted = value << calc_pkg::DIGIT_W;
  if (neg)
    return shifted - calc_pkg::data_t'(d);
  return shifted + calc_pkg::data_t'(d);
endfunction

function automatic calc_pkg::data_t apply_op(input calc_pkg::op_t op, input calc_pkg::data_t a,
                                             input calc_pkg::data_t b, input bit sgn,
                                             output bit div_zero);
  int q;
  div_zero = 1'b0;
  if (op == calc_pkg::OP_ADD)
    return a + b;
  if (op == calc_pkg::OP_SUB)
    return a - b;
  if (op == calc_pkg::OP_MUL)
    return a * b;
  if (b == '0)
  begin
    div_zero = 1'b1;
    return '0;
  end
  if (!sgn)
    return a / b;
  q = int'($signed(a)) / int'($signed(b));  // Integer divide truncates toward zero
  return q[15:0];
endfunction

// Applies one key to the model and tells what the display should show
function automatic void predict_key(input calc_pkg::key_code_t key, input bit sgn,
                                    output bit show, output calc_pkg::data_t word,
                                    output logic [3:0] lamps, output bit err);
  bit              dz;
  calc_pkg::data_t res;
  calc_pkg::data_t rhs;
  logic [3:0]      code;
  show = 1'b0;
  word = '0;
  code = key.func.code;
  if (m_state == M_ERROR)
  begin
    if (key.func.is_func && code == calc_pkg::KEY_AC)
    begin
      clear_model();
      show = 1'b1;
    end
  end
  else if (!key.digit.is_func)
  begin
    if (m_state == M_AFTER_EQ)
      clear_model();
    if (m_state == M_ENTER_B)
    begin
      m_b         = shift_digit(m_b, m_neg_b, key.digit.value);
      m_b_entered = 1'b1;
      word        = m_b;
    end
    else
    begin
      m_a  = shift_digit(m_a, m_neg_a, key.digit.value);
      word = m_a;
    end
    show = 1'b1;
  end
  else if (code < 4'd4 || code == calc_pkg::KEY_EQ)
  begin
    if (m_state == M_ENTER_B && (m_b_entered || code == calc_pkg::KEY_EQ))
    begin
      rhs = m_b_entered ? m_b : m_a;  // Equals without B repeats A
      res = apply_op(m_op, m_a, rhs, sgn, dz);
      if (dz)
      begin
        m_pending = 1'b0;
        m_state   = M_ERROR;
      end
      else
      begin
        m_a = res;
        clear_operand_b();
        show = 1'b1;
        word = m_a;
        m_pending = (code != calc_pkg::KEY_EQ);
        m_state   = (code == calc_pkg::KEY_EQ) ? M_AFTER_EQ : M_ENTER_B;
        if (code != calc_pkg::KEY_EQ)
          m_op = calc_pkg::op_t'(code[1:0]);
      end
    end
    else if (code != calc_pkg::KEY_EQ)
    begin
      m_op      = calc_pkg::op_t'(code[1:0]);
      m_pending = 1'b1;
      m_state   = M_ENTER_B;
      show      = 1'b1;
      word      = m_a;
    end
  end
  else if (code == calc_pkg::KEY_NEG && sgn)
  begin
    if (m_state == M_ENTER_B)
    begin
      m_b     = -m_b;
      m_neg_b = !m_neg_b;
      word    = m_b;
    end
    else
    begin
      m_a     = -m_a;
      m_neg_a = !m_neg_a;
      word    = m_a;
    end
    show = 1'b1;
  end
  else if (code == calc_pkg::KEY_AC)
  begin
    clear_model();
    show = 1'b1;
  end
  lamps = 4'b0000;
  if (m_pending)
    lamps[m_op] = 1'b1;
  err   = (m_state == M_ERROR);
endfunction

`endif

// File: test/tb_calc.sv
`timescale 1ns/1ns

module tb_calc;

  localparam int KEY_TIMEOUT  = 200;  // Cycles a key may wait for o_key_ready
  localparam int DISP_TIMEOUT = 200;
  localparam int QUIET_CYCLES = 12;   // An ignored key must stay silent this long

  typedef struct packed {
    calc_pkg::data_t word;
    logic [3:0]      lamps;
    logic            err;
  } disp_exp_t;

  logic                       clk;
  logic                       rst_n;
  logic [calc_pkg::KEY_W-1:0] i_key;
  logic                       i_key_valid;
  logic                       o_key_ready;
  logic                       i_signed_mode;
  calc_pkg::data_t            o_disp_data;
  logic                       o_disp_valid;
  logic                       i_disp_ready;
  logic [3:0]                 o_op_lamps;
  logic                       o_error;

  disp_exp_t exp_q[$];
  int        exp_count;
  int        recv_count;

  `include "calc_model.svh"

  calc_top i_dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_key         (i_key),
    .i_key_valid   (i_key_valid),
    .o_key_ready   (o_key_ready),
    .i_signed_mode (i_signed_mode),
    .o_disp_data   (o_disp_data),
    .o_disp_valid  (o_disp_valid),
    .i_disp_ready  (i_disp_ready),
    .o_op_lamps    (o_op_lamps),
    .o_error       (o_error)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic stop_on_error();
    $display("Simulation FAILED");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check_equal(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
      stop_on_error();
    end
  endtask

  function automatic calc_pkg::key_code_t digit_key(input logic [3:0] value);
    calc_pkg::key_code_t key;
    key.digit.is_func = 1'b0;
    key.digit.value   = value;
    return key;
  endfunction

  function automatic calc_pkg::key_code_t func_key(input logic [3:0] code);
    calc_pkg::key_code_t key;
    key.func.is_func = 1'b1;
    key.func.code    = code;
    return key;
  endfunction

  task automatic wait_drained();
    int waited;
    waited = 0;
    while (recv_count < exp_count)
    begin
      if (waited == DISP_TIMEOUT)
      begin
        $display("Timed out waiting for an expected display word");
        stop_on_error();
      end
      @(negedge clk);
      waited++;
    end
  endtask

  task automatic press(input calc_pkg::key_code_t key);
    bit              show;
    calc_pkg::data_t word;
    logic [3:0]      lamps;
    bit              err;
    int              waited;
    predict_key(key, i_signed_mode, show, word, lamps, err);
    if (show)
    begin
      exp_q.push_back({word, lamps, err});
      exp_count++;
    end
    @(negedge clk);
    i_key       = key;
    i_key_valid = 1'b1;
    waited      = 0;
    while (!o_key_ready)
    begin
      if (waited == KEY_TIMEOUT)
      begin
        $display("Timed out waiting for the DUT to accept a key");
        stop_on_error();
      end
      @(negedge clk);
      waited++;
    end
    @(negedge clk);  // The key went across on the rising edge just passed
    i_key_valid = 1'b0;
    if (show)
      wait_drained();
    else
      repeat (QUIET_CYCLES) @(negedge clk);
    check_equal("op lamps", 32'(o_op_lamps), 32'(lamps));
    check_equal("error flag", 32'(o_error), 32'(err));
  endtask

  task automatic press_op(input calc_pkg::op_t op);
    press(func_key({2'b00, op}));
  endtask

  // Enters the low n hex digits of value starting with the most significant
  task automatic enter_hex(input calc_pkg::data_t value, input int n);
    for (int i = n - 1; i >= 0; i--)
      press(digit_key(value[4*i +: 4]));
  endtask

  task automatic set_mode(input bit sgn);
    @(negedge clk);
    i_signed_mode = sgn;
  endtask

  initial
  begin
    i_disp_ready = 1'b0;
    forever
    begin
      @(negedge clk);
      i_disp_ready = ($urandom % 4) != 0;  // Back-pressure on about one cycle in four
    end
  end

  initial
  begin
    disp_exp_t expd;
    forever
    begin
      @(negedge clk);
      #1;
      if (o_disp_valid && i_disp_ready)
      begin
        if (exp_q.size() == 0)
        begin
          $display("The DUT offered display word %h when none was expected", o_disp_data);
          stop_on_error();
        end
        else
        begin
          expd = exp_q.pop_front();
          check_equal("display word", 32'(o_disp_data), 32'(expd.word));
          check_equal("lamps at display", 32'(o_op_lamps), 32'(expd.lamps));
          check_equal("error at display", 32'(o_error), 32'(expd.err));
          recv_count++;
        end
      end
    end
  end

  initial
  begin
    int r;
    void'($urandom(32'hb5a43743));
    rst_n         = 1'b0;
    i_key         = '0;
    i_key_valid   = 1'b0;
    i_signed_mode = 1'b0;
    exp_count     = 1;
    recv_count    = 0;
    clear_model();
    exp_q.push_back({16'h0000, 4'b0000, 1'b0});  // Reset shows the cleared A
    repeat (16) @(posedge clk);
    @(negedge clk);
    check_equal("key ready in reset", 32'(o_key_ready), 32'd0);
    check_equal("display valid in reset", 32'(o_disp_valid), 32'd0);
    check_equal("error in reset", 32'(o_error), 32'd0);
    check_equal("lamps in reset", 32'(o_op_lamps), 32'd0);
    rst_n = 1'b1;
    wait_drained();

    enter_hex(16'h1234, 4);
    press_op(calc_pkg::OP_ADD);
    enter_hex(16'h0abc, 3);
    press(func_key(calc_pkg::KEY_EQ));

    press(func_key(calc_pkg::KEY_AC));  // Unsigned chain wrapping past 2^16
    enter_hex(16'hfff0, 4);
    press_op(calc_pkg::OP_ADD);
    enter_hex(16'h0025, 2);
    press_op(calc_pkg::OP_SUB);
    enter_hex(16'h0100, 3);
    press_op(calc_pkg::OP_MUL);
    enter_hex(16'h0003, 1);
    press(func_key(calc_pkg::KEY_EQ));
    set_mode(1'b1);
    press(func_key(calc_pkg::KEY_AC));
    enter_hex(16'h007f, 2);
    press_op(calc_pkg::OP_MUL);
    enter_hex(16'h0203, 3);
    press_op(calc_pkg::OP_SUB);
    enter_hex(16'h1000, 4);
    press(func_key(calc_pkg::KEY_EQ));

    press(func_key(calc_pkg::KEY_AC));  // Negative entry on both operands
    press(func_key(calc_pkg::KEY_NEG));
    enter_hex(16'h0012, 2);
    press_op(calc_pkg::OP_ADD);
    press(func_key(calc_pkg::KEY_NEG));
    enter_hex(16'h0003, 1);
    press(func_key(calc_pkg::KEY_EQ));
    press(func_key(calc_pkg::KEY_NEG));
    set_mode(1'b0);
    press(func_key(calc_pkg::KEY_NEG));

    press(func_key(calc_pkg::KEY_AC));
    enter_hex(16'h0007, 1);
    press_op(calc_pkg::OP_MUL);
    press(func_key(calc_pkg::KEY_EQ));  // A times A
    press(func_key(calc_pkg::KEY_EQ));
    press(func_key(calc_pkg::KEY_AC));
    press(func_key(calc_pkg::KEY_EQ));
    enter_hex(16'h0003, 1);
    press_op(calc_pkg::OP_ADD);
    enter_hex(16'h0004, 1);
    press(func_key(calc_pkg::KEY_EQ));
    enter_hex(16'h0005, 1);

    set_mode(1'b1);
    press(func_key(calc_pkg::KEY_AC));  // The one signed quotient that overflows
    enter_hex(16'h8000, 4);
    press_op(calc_pkg::OP_DIV);
    press(func_key(calc_pkg::KEY_NEG));
    enter_hex(16'h0001, 1);
    press(func_key(calc_pkg::KEY_EQ));
    press(func_key(calc_pkg::KEY_AC));
    press(func_key(calc_pkg::KEY_NEG));
    enter_hex(16'h0007, 1);
    press_op(calc_pkg::OP_DIV);
    enter_hex(16'h0002, 1);
    press(func_key(calc_pkg::KEY_EQ));
    set_mode(1'b0);
    press(func_key(calc_pkg::KEY_AC));
    enter_hex(16'hfff0, 4);
    press_op(calc_pkg::OP_DIV);
    enter_hex(16'h0003, 1);
    press(func_key(calc_pkg::KEY_EQ));
    press(func_key(calc_pkg::KEY_AC));
    enter_hex(16'h0005, 1);
    press_op(calc_pkg::OP_DIV);
    enter_hex(16'h0000, 1);
    press(func_key(calc_pkg::KEY_EQ));  // Zero divisor locks the calculator
    enter_hex(16'h0001, 1);
    press_op(calc_pkg::OP_ADD);
    press(func_key(calc_pkg::KEY_EQ));
    press(func_key(calc_pkg::KEY_AC));

    for (int n = 0; n < 400; n++)
    begin
      if (($urandom % 40) == 0)
        set_mode(1'($urandom % 2));
      r = int'($urandom % 16);
      if (r < 8)
        press(digit_key(4'($urandom % 16)));
      else if (r < 14)
        press(func_key(4'($urandom % 6)));
      else if (r == 14)
        press(func_key(calc_pkg::KEY_AC));
      else
        press(func_key(4'(7 + $urandom % 9)));  // Unused codes
    end

    $display("Simulation PASSED");
    $finish;
  end

endmodule

// File: sim.f
+incdir+test
source/calc_pkg.sv
source/calc_ctrl_if.sv
source/calc_alu.sv
source/operand_datapath.sv
source/calc_sequencer.sv
source/calc_top.sv
test/tb_calc.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_calc
FILELIST = sim.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "^Simulation PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
